/* verilog/iob_wb_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, slave count and vector types of the IOb to Wishbone fabric
// Referenced by scoped name from the RTL and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package iob_wb_pkg;

   // Default bus widths
   localparam int IOB_WB_ADDR_W = 32;
   localparam int IOB_WB_DATA_W = 32;

   // Number of Wishbone slaves behind the fabric
   localparam int IOB_WB_N_SLAVES = 4;

   // Slave index lives in the top address bits
   localparam int IOB_WB_SEL_W = 2;

   // Bytes enabled on a read before the address shift
   localparam int IOB_WB_READ_BYTES = 4;

   // One byte lane
   typedef logic [7:0] byte_t;

   // Slave index taken from the address
   typedef logic [IOB_WB_SEL_W-1:0] slv_idx_t;

endpackage

/* verilog/iob_addr_decoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder of the fabric, routes IOb valid to one bridge and keeps
// the index of the bridge that owns the response, flags unmapped requests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iob_addr_decoder #(
   parameter int ADDR_W   = 32,
   parameter int N_SLAVES = 4
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  logic                 iob_valid_i,
   input  logic [ADDR_W-1:0]    iob_addr_i,
   input  logic                 iob_ready_i,
   output logic [N_SLAVES-1:0]  slv_valid_o,
   output iob_wb_pkg::slv_idx_t rsp_sel_o,
   output logic                 iob_err_o
);

   iob_wb_pkg::slv_idx_t idx;
   logic                 mapped;
   logic                 accept;

   // Slave index from the top address bits
   assign idx    = iob_addr_i[ADDR_W-1 -: iob_wb_pkg::IOB_WB_SEL_W];
   assign mapped = (int'(idx) < N_SLAVES);
   assign accept = iob_valid_i & iob_ready_i;

   // An index match implies a mapped slave here
   for (genvar i = 0; i < N_SLAVES; i++) begin : g_route
      assign slv_valid_o[i] = iob_valid_i & (idx == iob_wb_pkg::slv_idx_t'(i));
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_sel_o <= '0;
         iob_err_o <= 1'b0;
      end else begin
         // One-cycle pulse after an unmapped accept
         iob_err_o <= accept & ~mapped;
         // Unmapped requests leave the owner unchanged, so it stays idle
         if (accept && mapped) begin
            rsp_sel_o <= idx;
         end
      end
   end

endmodule

/* verilog/iob_iob2wishbone.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IOb to Wishbone classic bridge, one request per bus cycle
// Read data is returned one cycle after the slave ack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iob_iob2wishbone #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int READ_BYTES = 4
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   // IOb side
   input  logic                iob_valid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_rvalid_o,
   output logic [DATA_W-1:0]   iob_rdata_o,
   output logic                iob_ready_o,
   // Wishbone side
   output logic [ADDR_W-1:0]   wb_addr_o,
   output logic [DATA_W/8-1:0] wb_select_o,
   output logic                wb_we_o,
   output logic                wb_cyc_o,
   output logic                wb_stb_o,
   output logic [DATA_W-1:0]   wb_data_o,
   input  logic                wb_ack_i,
   input  logic [DATA_W-1:0]   wb_data_i
);

   localparam int NB = DATA_W / 8;

   // Low READ_BYTES lanes set
   function automatic logic [NB-1:0] rb_mask();
      logic [NB-1:0] m;
      for (int i = 0; i < NB; i++) begin
         m[i] = (i < READ_BYTES);
      end
      return m;
   endfunction

   localparam logic [NB-1:0] RB_MASK = rb_mask();

   logic              accept;
   logic              busy_r;
   logic              ack_r;
   logic              we_in;
   logic              we_r;
   logic [NB-1:0]     sel_in;
   logic [NB-1:0]     sel_r;
   logic [ADDR_W-1:0] addr_r;
   logic [DATA_W-1:0] wdata_r;
   logic [DATA_W-1:0] wdata_mux;
   logic [DATA_W-1:0] rdata_r;

   assign accept = iob_valid_i & iob_ready_o;
   assign we_in  = |iob_wstrb_i;
   assign sel_in = we_in ? iob_wstrb_i : RB_MASK << iob_addr_i[1:0];

   // Request goes straight out in the accept cycle, held copies after
   assign wb_cyc_o    = accept | busy_r;
   assign wb_stb_o    = wb_cyc_o;
   assign wb_addr_o   = accept ? iob_addr_i : addr_r;
   assign wb_we_o     = accept ? we_in : we_r;
   assign wb_select_o = accept ? sel_in : sel_r;
   assign wdata_mux   = accept ? iob_wdata_i : wdata_r;

   // Only strobed write lanes carry data on the bus
   for (genvar j = 0; j < NB; j++) begin : g_lane
      iob_wb_pkg::byte_t lane;
      assign lane = wdata_mux[j*8 +: 8];
      assign wb_data_o[j*8 +: 8] = (wb_we_o && wb_select_o[j]) ? lane : 8'h00;
   end

   assign iob_ready_o  = ~busy_r;
   assign iob_rvalid_o = ack_r & ~we_r;
   assign iob_rdata_o  = rdata_r;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_r <= 1'b0;
         ack_r  <= 1'b0;
         we_r   <= 1'b0;
      end else begin
         ack_r <= wb_ack_i & wb_cyc_o;
         // Ack ends the cycle, even one acked in its accept cycle
         if (wb_ack_i && wb_cyc_o) begin
            busy_r <= 1'b0;
         end else if (accept) begin
            busy_r <= 1'b1;
         end
         if (accept) begin
            we_r <= we_in;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_r  <= iob_addr_i;
         wdata_r <= iob_wdata_i;
         sel_r   <= sel_in;
      end
      if (wb_ack_i && wb_cyc_o) begin
         rdata_r <= wb_data_i;
      end
   end

endmodule

/* verilog/iob_rsp_mux.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response mux, returns ready, rvalid and rdata of the owning bridge
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iob_rsp_mux #(
   parameter int N_SLAVES = 4,
   parameter int DATA_W   = 32
) (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  iob_wb_pkg::slv_idx_t         rsp_sel_i,
   input  logic [N_SLAVES-1:0]          bridge_ready_i,
   input  logic [N_SLAVES-1:0]          bridge_rvalid_i,
   input  logic [N_SLAVES*DATA_W-1:0]   bridge_rdata_i,
   output logic                         iob_ready_o,
   output logic                         iob_rvalid_o,
   output logic [DATA_W-1:0]            iob_rdata_o
);

   logic              sel_ready;
   logic              sel_rvalid;
   logic [DATA_W-1:0] sel_rdata;

   always_comb begin
      sel_ready  = 1'b1;
      sel_rvalid = 1'b0;
      sel_rdata  = '0;
      for (int i = 0; i < N_SLAVES; i++) begin
         if (rsp_sel_i == iob_wb_pkg::slv_idx_t'(i)) begin
            sel_ready  = bridge_ready_i[i];
            sel_rvalid = bridge_rvalid_i[i];
            sel_rdata  = bridge_rdata_i[i*DATA_W +: DATA_W];
         end
      end
   end

   assign iob_ready_o  = sel_ready;
   assign iob_rvalid_o = sel_rvalid;
   // Stale read data is masked between responses
   assign iob_rdata_o  = iob_rvalid_o ? sel_rdata : '0;

endmodule

/* verilog/iob_wb_split.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the IOb to Wishbone fabric, one IOb port to N_SLAVES slaves
// Per-slave Wishbone buses are flat vectors indexed by slave number
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iob_wb_split #(
   parameter int ADDR_W     = iob_wb_pkg::IOB_WB_ADDR_W,
   parameter int DATA_W     = iob_wb_pkg::IOB_WB_DATA_W,
   parameter int N_SLAVES   = iob_wb_pkg::IOB_WB_N_SLAVES,
   parameter int READ_BYTES = iob_wb_pkg::IOB_WB_READ_BYTES
) (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   // IOb master port
   input  logic                           iob_valid_i,
   input  logic [ADDR_W-1:0]              iob_addr_i,
   input  logic [DATA_W-1:0]              iob_wdata_i,
   input  logic [DATA_W/8-1:0]            iob_wstrb_i,
   // Kept for IOb port compatibility only
   input  logic                           iob_rready_i,
   output logic                           iob_rvalid_o,
   output logic [DATA_W-1:0]              iob_rdata_o,
   output logic                           iob_ready_o,
   output logic                           iob_err_o,
   // Wishbone slave buses
   output logic [N_SLAVES*ADDR_W-1:0]     wb_addr_o,
   output logic [N_SLAVES*DATA_W/8-1:0]   wb_select_o,
   output logic [N_SLAVES-1:0]            wb_we_o,
   output logic [N_SLAVES-1:0]            wb_cyc_o,
   output logic [N_SLAVES-1:0]            wb_stb_o,
   output logic [N_SLAVES*DATA_W-1:0]     wb_data_o,
   input  logic [N_SLAVES-1:0]            wb_ack_i,
   input  logic [N_SLAVES*DATA_W-1:0]     wb_data_i
);

   localparam int NB = DATA_W / 8;

   logic [N_SLAVES-1:0]        slv_valid;
   iob_wb_pkg::slv_idx_t       rsp_sel;
   logic [N_SLAVES-1:0]        bridge_ready;
   logic [N_SLAVES-1:0]        bridge_rvalid;
   logic [N_SLAVES*DATA_W-1:0] bridge_rdata;

   iob_addr_decoder #(
      .ADDR_W  (ADDR_W),
      .N_SLAVES(N_SLAVES)
   ) u_decoder (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .iob_valid_i(iob_valid_i),
      .iob_addr_i (iob_addr_i),
      .iob_ready_i(iob_ready_o),
      .slv_valid_o(slv_valid),
      .rsp_sel_o  (rsp_sel),
      .iob_err_o  (iob_err_o)
   );

   for (genvar i = 0; i < N_SLAVES; i++) begin : g_bridge
      iob_iob2wishbone #(
         .ADDR_W    (ADDR_W),
         .DATA_W    (DATA_W),
         .READ_BYTES(READ_BYTES)
      ) u_bridge (
         .clk_i       (clk_i),
         .arst_n_i    (arst_n_i),
         .iob_valid_i (slv_valid[i]),
         .iob_addr_i  (iob_addr_i),
         .iob_wdata_i (iob_wdata_i),
         .iob_wstrb_i (iob_wstrb_i),
         .iob_rvalid_o(bridge_rvalid[i]),
         .iob_rdata_o (bridge_rdata[i*DATA_W +: DATA_W]),
         .iob_ready_o (bridge_ready[i]),
         .wb_addr_o   (wb_addr_o[i*ADDR_W +: ADDR_W]),
         .wb_select_o (wb_select_o[i*NB +: NB]),
         .wb_we_o     (wb_we_o[i]),
         .wb_cyc_o    (wb_cyc_o[i]),
         .wb_stb_o    (wb_stb_o[i]),
         .wb_data_o   (wb_data_o[i*DATA_W +: DATA_W]),
         .wb_ack_i    (wb_ack_i[i]),
         .wb_data_i   (wb_data_i[i*DATA_W +: DATA_W])
      );
   end

   iob_rsp_mux #(
      .N_SLAVES(N_SLAVES),
      .DATA_W  (DATA_W)
   ) u_rsp_mux (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .rsp_sel_i      (rsp_sel),
      .bridge_ready_i (bridge_ready),
      .bridge_rvalid_i(bridge_rvalid),
      .bridge_rdata_i (bridge_rdata),
      .iob_ready_o    (iob_ready_o),
      .iob_rvalid_o   (iob_rvalid_o),
      .iob_rdata_o    (iob_rdata_o)
   );

endmodule

/* tests/wb_slave_model.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave memory for the testbench, acks LATENCY cycles
// after the cycle starts and returns only the selected lanes on a read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_slave_model #(
   parameter int ADDR_W  = 32,
   parameter int DATA_W  = 32,
   parameter int LATENCY = 1
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [ADDR_W-1:0]   wb_addr_i,
   input  logic [DATA_W/8-1:0] wb_select_i,
   input  logic [DATA_W-1:0]   wb_data_i,
   output logic                wb_ack_o,
   output logic [DATA_W-1:0]   wb_data_o
);

   logic [DATA_W-1:0] mem [16];
   logic [DATA_W-1:0] wr_word;
   logic [DATA_W-1:0] rd_word;
   logic [3:0]        widx;
   int                cnt;

   assign widx = wb_addr_i[5:2];

   for (genvar j = 0; j < DATA_W / 8; j++) begin : g_lane
      iob_wb_pkg::byte_t old_b;
      assign old_b = mem[widx][j*8 +: 8];
      assign wr_word[j*8 +: 8] = wb_select_i[j] ? wb_data_i[j*8 +: 8] : old_b;
      assign rd_word[j*8 +: 8] = wb_select_i[j] ? old_b : 8'h00;
   end

   initial begin
      for (int i = 0; i < 16; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o  <= 1'b0;
         wb_data_o <= '0;
         cnt       <= 0;
      end else if (wb_ack_o || !(wb_cyc_i && wb_stb_i)) begin
         // Ack lasts one cycle
         wb_ack_o <= 1'b0;
         cnt      <= 0;
      end else if (cnt == LATENCY - 1) begin
         wb_ack_o <= 1'b1;
         if (wb_we_i) begin
            mem[widx] = wr_word;
         end else begin
            wb_data_o <= rd_word;
         end
      end else begin
         cnt <= cnt + 1;
      end
   end

endmodule

/* tests/iob_wb_split_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the IOb to Wishbone fabric with three slave memories
// Directed and random accesses are checked against a shadow memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module iob_wb_split_tb;

   localparam int ADDR_W = iob_wb_pkg::IOB_WB_ADDR_W;
   localparam int DATA_W = iob_wb_pkg::IOB_WB_DATA_W;
   localparam int RD_B   = iob_wb_pkg::IOB_WB_READ_BYTES;
   localparam int N_SLV  = 3;
   localparam int NB     = DATA_W / 8;
   localparam int TMO    = 20;

   logic                    clk;
   logic                    arst_n;
   logic                    iob_valid;
   logic [ADDR_W-1:0]       iob_addr;
   logic [DATA_W-1:0]       iob_wdata;
   logic [NB-1:0]           iob_wstrb;
   logic                    iob_rvalid;
   logic [DATA_W-1:0]       iob_rdata;
   logic                    iob_ready;
   logic                    iob_err;
   logic [N_SLV*ADDR_W-1:0] wb_addr;
   logic [N_SLV*NB-1:0]     wb_sel;
   logic [N_SLV-1:0]        wb_we;
   logic [N_SLV-1:0]        wb_cyc;
   logic [N_SLV-1:0]        wb_stb;
   logic [N_SLV-1:0]        wb_ack;
   logic [N_SLV*DATA_W-1:0] wb_wdata;
   logic [N_SLV*DATA_W-1:0] wb_rdata;

   logic [DATA_W-1:0] shadow [N_SLV][16];
   logic [DATA_W-1:0] exp_q [$];
   logic [31:0]       rng;
   string             test_name;
   int                err_cnt;
   int                check_cnt;
   int                test_cnt;
   int                fail_cnt;
   int                test_err0;

   iob_wb_split #(
      .N_SLAVES(N_SLV)
   ) u_iob_wb_split (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .iob_valid_i (iob_valid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_rready_i(1'b1),
      .iob_rvalid_o(iob_rvalid),
      .iob_rdata_o (iob_rdata),
      .iob_ready_o (iob_ready),
      .iob_err_o   (iob_err),
      .wb_addr_o   (wb_addr),
      .wb_select_o (wb_sel),
      .wb_we_o     (wb_we),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_data_o   (wb_wdata),
      .wb_ack_i    (wb_ack),
      .wb_data_i   (wb_rdata)
   );

   // Slave s acks after s+1 cycles
   for (genvar s = 0; s < N_SLV; s++) begin : g_slave
      wb_slave_model #(
         .ADDR_W (ADDR_W),
         .DATA_W (DATA_W),
         .LATENCY(s + 1)
      ) u_slave (
         .clk_i      (clk),
         .arst_n_i   (arst_n),
         .wb_cyc_i   (wb_cyc[s]),
         .wb_stb_i   (wb_stb[s]),
         .wb_we_i    (wb_we[s]),
         .wb_addr_i  (wb_addr[s*ADDR_W +: ADDR_W]),
         .wb_select_i(wb_sel[s*NB +: NB]),
         .wb_data_i  (wb_wdata[s*DATA_W +: DATA_W]),
         .wb_ack_o   (wb_ack[s]),
         .wb_data_o  (wb_rdata[s*DATA_W +: DATA_W])
      );
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // Read lanes: READ_BYTES lanes starting at the low address bits
   function automatic logic [NB-1:0] read_lanes(input logic [1:0] low);
      logic [NB-1:0] s;
      for (int i = 0; i < NB; i++) begin
         s[i] = (i >= int'(low)) && (i < int'(low) + RD_B);
      end
      return s;
   endfunction

   // New shadow word for a write, or the expected read word
   function automatic logic [DATA_W-1:0] ref_model(input logic [DATA_W-1:0] old,
         input logic [DATA_W-1:0] wdata, input logic [NB-1:0] wstrb, input logic [1:0] low);
      logic [DATA_W-1:0] r;
      logic [NB-1:0]     rd;
      rd = read_lanes(low);
      for (int i = 0; i < NB; i++) begin
         if (wstrb == '0) begin
            r[i*8 +: 8] = rd[i] ? old[i*8 +: 8] : 8'h00;
         end else begin
            r[i*8 +: 8] = wstrb[i] ? wdata[i*8 +: 8] : old[i*8 +: 8];
         end
      end
      return r;
   endfunction

   task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
      check_cnt++;
      if (exp_v !== act_v) begin
         err_cnt++;
         $display("ERR %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
      end
   endtask

   // Every read response is matched against the oldest expectation
   always @(negedge clk) begin
      if (iob_rvalid) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("Read data returned with no read outstanding in %s", test_name);
         end else begin
            check("rdata", exp_q.pop_front(), iob_rdata);
         end
      end else begin
         check("idle rdata", 32'd0, iob_rdata);
      end
   end

   task automatic start_test(input string name);
      test_name = name;
      test_err0 = err_cnt;
   endtask

   task automatic end_test();
      int t;
      t = 0;
      while (exp_q.size() != 0 && t < TMO) begin
         @(negedge clk);
         t++;
      end
      if (exp_q.size() != 0) begin
         err_cnt++;
         $display("Some reads in %s never returned data", test_name);
         exp_q.delete();
      end
      test_cnt++;
      if (err_cnt != test_err0) begin
         fail_cnt++;
      end
      $display("%s: %s", test_name, (err_cnt == test_err0) ? "ok" : "FAILED");
   endtask

   // One access; a zero strobe makes it a read
   task automatic run_access(input int slv, input logic [3:0] word, input logic [1:0] low,
                             input logic [DATA_W-1:0] wdata, input logic [NB-1:0] wstrb);
      logic [N_SLV-1:0] cyc_seen;
      logic [N_SLV-1:0] cyc_exp;
      logic             done;
      int               t;
      cyc_seen     = '0;
      cyc_exp      = '0;
      cyc_exp[slv] = 1'b1;
      if (wstrb == '0) begin
         exp_q.push_back(ref_model(shadow[slv][word], wdata, wstrb, low));
      end else begin
         shadow[slv][word] = ref_model(shadow[slv][word], wdata, wstrb, low);
      end
      @(posedge clk);
      #1;
      iob_valid = 1'b1;
      iob_addr  = {iob_wb_pkg::slv_idx_t'(slv), 24'h0, word, low};
      iob_wdata = wdata;
      iob_wstrb = wstrb;
      t = 0;
      @(negedge clk);
      while (!iob_ready && t < TMO) begin
         @(negedge clk);
         t++;
      end
      if (!iob_ready) begin
         err_cnt++;
         $display("Timeout: ready stayed low before an access in %s", test_name);
         iob_valid = 1'b0;
         return;
      end
      cyc_seen = wb_cyc;
      check("stb at accept", 32'(cyc_exp), 32'(wb_stb));
      check("wb addr", iob_addr, wb_addr[slv*ADDR_W +: ADDR_W]);
      if (wstrb == '0) begin
         check("read select", 32'(read_lanes(low)), 32'(wb_sel[slv*NB +: NB]));
         check("read we", 32'd0, 32'(wb_we[slv]));
      end
      @(posedge clk);
      #1;
      iob_valid = 1'b0;
      iob_wstrb = '0;
      done = 1'b0;
      t = 0;
      while (!done && t < TMO) begin
         @(negedge clk);
         cyc_seen = cyc_seen | wb_cyc;
         done = (wstrb == '0) ? iob_rvalid : iob_ready;
         t++;
      end
      if (!done) begin
         err_cnt++;
         $display("Timeout: access to slave %0d never completed in %s", slv, test_name);
      end else begin
         if (wstrb == '0) begin
            check("ready at end", 32'd1, 32'(iob_ready));
         end
         check("cyc per slave", 32'(cyc_exp), 32'(cyc_seen));
      end
   endtask

   task automatic run_unmapped(input logic [3:0] word);
      logic seen_err;
      int   t;
      @(posedge clk);
      #1;
      iob_valid = 1'b1;
      iob_addr  = {iob_wb_pkg::slv_idx_t'(N_SLV), 24'h0, word, 2'b00};
      iob_wstrb = '1;
      @(negedge clk);
      check("ready unmapped", 32'd1, 32'(iob_ready));
      check("cyc at accept", 32'd0, 32'(wb_cyc));
      @(posedge clk);
      #1;
      iob_valid = 1'b0;
      iob_wstrb = '0;
      seen_err = 1'b0;
      t = 0;
      while (!seen_err && t < TMO) begin
         @(negedge clk);
         check("cyc after accept", 32'd0, 32'(wb_cyc));
         seen_err = iob_err;
         t++;
      end
      if (!seen_err) begin
         err_cnt++;
         $display("Timeout: no error pulse for an unmapped address in %s", test_name);
      end else begin
         @(negedge clk);
         check("err pulse width", 32'd0, 32'(iob_err));
      end
   endtask

   initial begin
      logic [31:0] r;
      rng       = 32'h851;
      err_cnt   = 0;
      check_cnt = 0;
      test_cnt  = 0;
      fail_cnt  = 0;
      test_err0 = 0;
      test_name = "reset";
      iob_valid = 1'b0;
      iob_addr  = '0;
      iob_wdata = '0;
      iob_wstrb = '0;
      arst_n    = 1'b0;
      for (int s = 0; s < N_SLV; s++) begin
         for (int w = 0; w < 16; w++) begin
            shadow[s][w] = '0;
         end
      end
      repeat (4) @(posedge clk);
      #1;
      arst_n = 1'b1;

      start_test("write_read");
      run_access(0, 4'd3, 2'd0, 32'hDEADBEEF, 4'hF);
      run_access(0, 4'd3, 2'd0, '0, 4'h0);
      end_test();

      start_test("per_slave");
      for (int s = 0; s < N_SLV; s++) begin
         run_access(s, 4'd7, 2'd0, 32'hC0DE0000 + s, 4'hF);
      end
      for (int s = 0; s < N_SLV; s++) begin
         run_access(s, 4'd7, 2'd0, '0, 4'h0);
      end
      end_test();

      start_test("partial");
      run_access(1, 4'd5, 2'd0, 32'h11223344, 4'hF);
      run_access(1, 4'd5, 2'd0, 32'hAABBCCDD, 4'b0010);
      run_access(1, 4'd5, 2'd0, 32'h55667788, 4'b1100);
      run_access(1, 4'd5, 2'd0, 32'h000000EE, 4'b0001);
      run_access(1, 4'd5, 2'd0, '0, 4'h0);
      end_test();

      start_test("read_select");
      run_access(2, 4'd9, 2'd0, 32'h89ABCDEF, 4'hF);
      for (int l = 0; l < 4; l++) begin
         run_access(2, 4'd9, 2'(l), '0, 4'h0);
      end
      end_test();

      start_test("unmapped");
      run_unmapped(4'd1);
      run_access(1, 4'd2, 2'd0, 32'h0BADF00D, 4'hF);
      run_access(1, 4'd2, 2'd0, '0, 4'h0);
      end_test();

      start_test("random");
      for (int n = 0; n < 200; n++) begin
         rng = xorshift32(rng);
         r   = rng;
         rng = xorshift32(rng);
         run_access(int'(r % N_SLV), r[5:2], r[9:8], rng, r[20] ? 4'h0 : r[15:12]);
      end
      end_test();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_cnt, fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* sources.f */
verilog/iob_wb_pkg.sv
verilog/iob_addr_decoder.sv
verilog/iob_iob2wishbone.sv
verilog/iob_rsp_mux.sv
verilog/iob_wb_split.sv
tests/wb_slave_model.sv
tests/iob_wb_split_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fabric testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module iob_wb_split_tb -f sources.f || exit 1
out=$(./obj_dir/Viob_wb_split_tb)
echo "$out"
echo "$out" | grep -q "^All tests passed$" && exit 0 || exit 1
